//--- dmac_top.f
hdl/dmac_pkg.sv
hdl/dmac_desc_if.sv
hdl/dmac_regs.sv
hdl/dmac_desc_fifo.sv
hdl/dmac_engine.sv
hdl/dmac_top.sv
dv/dmac_checker.sv
dv/dmac_tb.sv

//--- dv/dmac_checker.sv
// Bound assertions on the master bus strobes and reset state
module dmac_checker (
	input logic clk,
	input logic reset_n,
	input logic m_req,
	input logic m_wr,
	input logic s_interrupt
);
	a_wr_has_req: assert property (@(posedge clk) disable iff (!reset_n) m_wr |-> m_req)
		else $error("m_wr asserted without m_req");

	a_wr_single: assert property (@(posedge clk) disable iff (!reset_n) m_wr |=> !m_wr)
		else $error("m_wr high in two consecutive cycles");

	// Outputs settle after the first reset edge
	a_reset_quiet: assert property (@(posedge clk)
		(!reset_n && $past(!reset_n)) |-> (!m_req && !m_wr && !s_interrupt))
		else $error("Master strobes or interrupt active during reset");
endmodule

bind dmac_top dmac_checker u_checker (
	.clk         (clk),
	.reset_n     (reset_n),
	.m_req       (m_req),
	.m_wr        (m_wr),
	.s_interrupt (s_interrupt)
);

//--- dv/dmac_tb.sv
// Testbench for the DMA controller: memory model, grant driver, register and copy tests
module dmac_tb;
	import dmac_pkg::*;

	localparam int DEPTH      = DESC_DEPTH_DEFAULT;
	localparam int MAX_CYCLES = 20000; // 6 tests x 17 descriptors x 31 words x 2, plus registers

	logic        clk = 1'b0;
	logic        reset_n, s_sel, s_wr, m_req, m_wr, s_interrupt;
	logic        m_grant = 1'b0;
	logic [15:0] s_addr;
	word_t       s_din, s_dout, m_dout;
	word_t       m_din = '0;
	addr_t       m_addr;

	word_t mem [0:65535];
	word_t ref_mem [0:65535]; // Expected memory after each copy
	word_t fill_salt;
	int    seed = 47849;
	int    cycles = 0;
	int    wr_count = 0;
	int    grant_delay = 0;
	int    grant_cnt = 0;
	int    exp_words;
	int    slot = 0; // Next free source and destination range

	always #10 clk = ~clk;

	dmac_top #(.DESC_DEPTH(DEPTH)) u_dmac_top (.*);

	function automatic word_t fill_word(input int unsigned a);
		return {~a[15:0], a[15:0]} ^ fill_salt;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	always @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 65536; i++)
				mem[i] = fill_word(i);
			m_din <= '0;
		end else begin
			m_din <= mem[m_addr]; // Answer one cycle after the address
			if (m_wr)
				mem[m_addr] = m_dout;
		end
	end

	always @(posedge clk) begin
		if (!reset_n || !m_req) begin
			m_grant   <= 1'b0;
			grant_cnt <= 0;
		end else if (grant_cnt >= grant_delay)
			m_grant <= 1'b1;
		else
			grant_cnt <= grant_cnt + 1;
	end

	always @(negedge clk) begin
		if (m_wr) begin
			wr_count = wr_count + 1;
			check_value("m_grant at m_wr", word_t'(m_grant), 32'h1);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES)
			abort_run("Timeout: the DUT did not finish within the cycle limit");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL time %0t %s: got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_n <= 1'b0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
	endtask

	task automatic write_reg(input reg_addr_t off, input word_t data);
		@(posedge clk);
		s_sel  <= 1'b1;
		s_wr   <= 1'b1;
		s_addr <= {8'h00, off};
		s_din  <= data;
		@(posedge clk);
		s_sel <= 1'b0;
		s_wr  <= 1'b0;
	endtask

	task automatic expect_reg(input string name, input reg_addr_t off, input word_t exp);
		@(posedge clk);
		s_sel  <= 1'b1;
		s_wr   <= 1'b0;
		s_addr <= {8'h00, off};
		@(posedge clk);
		s_sel <= 1'b0;
		@(negedge clk);
		check_value(name, s_dout, exp); // s_dout loaded at the last edge
	endtask

	task automatic wait_status(input status_t st);
		do begin
			@(negedge clk);
			check_value("s_interrupt", word_t'(s_interrupt), 32'h0);
		end while (u_dmac_top.status != st);
	endtask

	task automatic add_desc(input bit zeros);
		addr_t src;
		addr_t dest;
		size_t size;
		src  = addr_t'(16'h1000 + slot * 32);
		dest = addr_t'(16'h9000 + slot * 32);
		size = (zeros && rand_below(3) == 0) ? size_t'(0) : size_t'(1 + rand_below(31));
		slot = slot + 1;
		for (int i = 0; i < int'(size); i++)
			ref_mem[addr_t'(int'(dest) + i)] = ref_mem[addr_t'(int'(src) + i)];
		exp_words = exp_words + int'(size);
		write_reg(REG_SRC, word_t'(src));
		write_reg(REG_DEST, word_t'(dest));
		write_reg(REG_SIZE, word_t'(size));
		write_reg(REG_PUSH, 32'h1);
	endtask

	task automatic start_copy();
		grant_delay = rand_below(8);
		write_reg(REG_START, 32'h1);
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 65536; i++)
			if (mem[i] !== ref_mem[i])
				check_value($sformatf("mem[%04h]", i), mem[i], ref_mem[i]);
	endtask

	// Push n descriptors, start once, wait for the interrupt and check the copy
	task automatic run_chain(input int n, input bit zeros);
		int wr_before;
		wr_before = wr_count;
		exp_words = 0;
		repeat (n) add_desc(zeros);
		start_copy();
		do @(negedge clk); while (!s_interrupt);
		check_value("m_req", word_t'(m_req), 32'h0); // Bus released in DONE
		expect_reg("status", REG_STATUS, word_t'(ST_DONE));
		expect_reg("intr", REG_INTR, 32'h1);
		write_reg(REG_INTR, 32'h1);
		expect_reg("status", REG_STATUS, word_t'(ST_IDLE));
		check_value("m_wr cycles", word_t'(wr_count - wr_before), word_t'(exp_words));
		compare_memory();
	endtask

	initial begin
		word_t v;
		reset_n = 1'b0;
		s_sel = 1'b0;
		s_wr = 1'b0;
		s_addr = '0;
		s_din = '0;
		fill_salt = $random(seed);
		for (int i = 0; i < 65536; i++)
			ref_mem[i] = fill_word(i);
		apply_reset();

		v = $random(seed);
		write_reg(REG_SRC, v);
		write_reg(REG_DEST, ~v);
		write_reg(REG_SIZE, v);
		write_reg(REG_INTR_EN, v);
		write_reg(8'h07, v); // Unmapped
		write_reg(REG_START, v & ~32'h1); // Upper bits only, no strobe
		write_reg(REG_PUSH, v & ~32'h1);
		expect_reg("src", REG_SRC, v & 32'hffff);
		expect_reg("dest", REG_DEST, ~v & 32'hffff);
		expect_reg("size", REG_SIZE, v & 32'h1f);
		expect_reg("intr_en", REG_INTR_EN, v & 32'h1);
		expect_reg("start", REG_START, 32'h0);
		expect_reg("push", REG_PUSH, 32'h0);
		expect_reg("unmapped 07", 8'h07, 32'h0);
		expect_reg("unmapped ff", 8'hff, 32'h0);
		expect_reg("status", REG_STATUS, word_t'(ST_IDLE));

		write_reg(REG_INTR_EN, 32'h1);
		run_chain(1, 1'b0);
		run_chain(1 + rand_below(8), 1'b1);
		repeat (2) run_chain(1 + rand_below(8), 1'b0); // Random grant delays

		write_reg(REG_INTR_EN, 32'h0);
		exp_words = 0;
		add_desc(1'b0);
		start_copy();
		wait_status(ST_DONE);
		repeat (4) wait_status(ST_DONE); // Interrupt stays low while pending
		expect_reg("intr", REG_INTR, 32'h1);
		write_reg(REG_INTR, 32'h1);
		expect_reg("status", REG_STATUS, word_t'(ST_IDLE));
		compare_memory();
		start_copy(); // Empty FIFO
		expect_reg("start", REG_START, 32'h0);
		wait_status(ST_DONE);
		expect_reg("status", REG_STATUS, word_t'(ST_DONE));
		write_reg(REG_INTR, 32'h1);
		expect_reg("status", REG_STATUS, word_t'(ST_IDLE));

		repeat (DEPTH + 1) write_reg(REG_PUSH, 32'h1);
		expect_reg("push", REG_PUSH, 32'h0);
		expect_reg("status", REG_STATUS, word_t'(ST_FAULT));
		check_value("m_req", word_t'(m_req), 32'h0);
		start_copy();
		write_reg(REG_INTR, 32'h1);
		expect_reg("status", REG_STATUS, word_t'(ST_FAULT));
		apply_reset();
		expect_reg("status", REG_STATUS, word_t'(ST_IDLE));

		$display("Regression passed");
		$finish;
	end

endmodule

//--- hdl/dmac_desc_fifo.sv
// Descriptor FIFO: circular buffer of whole descriptors with overflow pulse
module dmac_desc_fifo #(
	parameter int DESC_DEPTH = dmac_pkg::DESC_DEPTH_DEFAULT
) (
	input  logic      clk,
	input  logic      reset_n,
	desc_push_if.fifo wr,
	desc_pop_if.fifo  rd,
	output logic      overflow
);
	import dmac_pkg::*;

	localparam int PTR_W = $clog2(DESC_DEPTH);

	addr_t src_mem  [DESC_DEPTH];
	addr_t dest_mem [DESC_DEPTH];
	size_t size_mem [DESC_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full     = (count == (PTR_W + 1)'(DESC_DEPTH));
	assign rd.empty = (count == '0);
	assign do_push  = wr.push & ~full;
	assign do_pop   = rd.pop & ~rd.empty;
	assign overflow = wr.push & full; // Descriptor is dropped

	always_ff @(posedge clk) begin
		if (do_push) begin
			src_mem[tail]  <= wr.src;
			dest_mem[tail] <= wr.dest;
			size_mem[tail] <= wr.size;
		end
	end

	// Pointers wrap on their own for a power-of-two depth
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail <= tail + 1'b1;
			if (do_pop)
				head <= head + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assign rd.src  = src_mem[head];
	assign rd.dest = dest_mem[head];
	assign rd.size = size_mem[head];

endmodule

//--- hdl/dmac_desc_if.sv
// Descriptor push and pop interfaces
interface desc_push_if;
	import dmac_pkg::*;

	logic  push; // One-cycle strobe
	addr_t src;
	addr_t dest;
	size_t size;

	modport regs (
		output push,
		output src,
		output dest,
		output size
	);

	modport fifo (
		input push,
		input src,
		input dest,
		input size
	);
endinterface

interface desc_pop_if;
	import dmac_pkg::*;

	logic  pop;
	logic  empty;
	addr_t src;  // Head descriptor, valid while not empty
	addr_t dest;
	size_t size;

	modport fifo (
		input  pop,
		output empty,
		output src,
		output dest,
		output size
	);

	modport engine (
		output pop,
		input  empty,
		input  src,
		input  dest,
		input  size
	);
endinterface

//--- hdl/dmac_engine.sv
// Bus-master copy engine: FSM, address and count registers, bus output decode
module dmac_engine (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              start,
	input  logic              irq_pending,
	input  logic              overflow,
	output logic              done,
	output dmac_pkg::status_t status,
	desc_pop_if.engine        desc,
	output logic              m_req,
	input  logic              m_grant,
	output logic              m_wr,
	output dmac_pkg::addr_t   m_addr,
	output dmac_pkg::word_t   m_dout,
	input  dmac_pkg::word_t   m_din
);
	import dmac_pkg::*;

	engine_state_t state;
	engine_state_t state_next;
	addr_t         src_r;
	addr_t         dest_r;
	size_t         count_r;
	logic          bus_owned; // Grant seen since this start

	always_comb begin
		state_next = state;
		if (overflow) begin
			state_next = E_FAULT;
		end else begin
			case (state)
				E_IDLE: begin
					if (start)
						state_next = desc.empty ? E_DONE : E_POP;
				end
				E_POP: begin
					if (desc.empty)
						state_next = E_DONE; // Chain ended on a zero-size descriptor
					else if (desc.size == '0)
						state_next = E_POP;
					else if (bus_owned)
						state_next = E_READ;
					else
						state_next = E_REQ;
				end
				E_REQ: begin
					if (m_grant)
						state_next = E_READ;
				end
				E_READ: state_next = E_WRITE;
				E_WRITE: begin
					if (count_r > size_t'(1))
						state_next = E_READ;
					else if (!desc.empty)
						state_next = E_POP;
					else
						state_next = E_DONE;
				end
				E_DONE: begin
					if (!irq_pending)
						state_next = E_IDLE;
				end
				E_FAULT: state_next = E_FAULT;
				default: state_next = E_FAULT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			state <= E_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			bus_owned <= 1'b0;
		else if (state_next == E_DONE || state_next == E_FAULT)
			bus_owned <= 1'b0;
		else if (state == E_REQ && m_grant)
			bus_owned <= 1'b1;
	end

	// Descriptor load and per-word update
	always_ff @(posedge clk) begin
		if (desc.pop) begin
			src_r   <= desc.src;
			dest_r  <= desc.dest;
			count_r <= desc.size;
		end else if (state == E_WRITE) begin
			src_r   <= src_r + 1'b1;
			dest_r  <= dest_r + 1'b1;
			count_r <= count_r - 1'b1;
		end
	end

	assign desc.pop = (state == E_POP) && !desc.empty;

	// Same edge that enters E_DONE sets the pending flag in the regs
	assign done = (state != E_DONE) && (state_next == E_DONE);

	always_comb begin
		case (state)
			E_IDLE:  status = ST_IDLE;
			E_DONE:  status = ST_DONE;
			E_FAULT: status = ST_FAULT;
			default: status = ST_BUSY;
		endcase
	end

	always_comb begin
		m_req  = 1'b0;
		m_wr   = 1'b0;
		m_addr = '0;
		m_dout = '0;
		case (state)
			E_POP:  m_req = bus_owned; // Keep the bus between descriptors
			E_REQ:  m_req = 1'b1;
			E_READ: begin
				m_req  = 1'b1;
				m_addr = src_r;
			end
			E_WRITE: begin
				m_req  = 1'b1;
				m_wr   = 1'b1;
				m_addr = dest_r;
				m_dout = m_din; // Read data from the previous cycle
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/dmac_pkg.sv
// DMA controller package: bus widths, register offsets, status codes, engine states
package dmac_pkg;

	typedef logic [31:0] word_t;     // Data word on master and slave bus
	typedef logic [15:0] addr_t;     // Master bus address
	typedef logic [4:0]  size_t;     // Words per descriptor
	typedef logic [7:0]  reg_addr_t; // Slave register offset

	// Slave register map
	localparam reg_addr_t REG_START   = 8'h00;
	localparam reg_addr_t REG_INTR    = 8'h01;
	localparam reg_addr_t REG_INTR_EN = 8'h02;
	localparam reg_addr_t REG_SRC     = 8'h03;
	localparam reg_addr_t REG_DEST    = 8'h04;
	localparam reg_addr_t REG_SIZE    = 8'h05;
	localparam reg_addr_t REG_PUSH    = 8'h06;
	localparam reg_addr_t REG_STATUS  = 8'h08;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_BUSY  = 2'd1,
		ST_DONE  = 2'd2,
		ST_FAULT = 2'd3
	} status_t;

	typedef enum logic [2:0] {
		E_IDLE,
		E_POP,
		E_REQ,
		E_READ,
		E_WRITE,
		E_DONE,
		E_FAULT
	} engine_state_t;

	localparam int DESC_DEPTH_DEFAULT = 16;

endpackage

//--- hdl/dmac_regs.sv
// Slave register block: register decode, readback, interrupt, descriptor staging
module dmac_regs (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             s_sel,
	input  logic             s_wr,
	input  logic [15:0]      s_addr,
	input  dmac_pkg::word_t  s_din,
	output dmac_pkg::word_t  s_dout,
	output logic             s_interrupt,
	output logic             start,
	output logic             irq_pending,
	input  logic             done,
	input  dmac_pkg::status_t status,
	desc_push_if.regs        desc
);
	import dmac_pkg::*;

	reg_addr_t offset;
	logic      wr_en;
	logic      rd_en;
	logic      intr_en;
	logic      push;
	addr_t     src_r;
	addr_t     dest_r;
	size_t     size_r;
	word_t     rd_data;

	assign offset = s_addr[7:0];
	assign wr_en  = s_sel & s_wr;
	assign rd_en  = s_sel & ~s_wr;

	// Staged descriptor fields
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (offset)
				REG_SRC:  src_r  <= s_din[15:0];
				REG_DEST: dest_r <= s_din[15:0];
				REG_SIZE: size_r <= s_din[4:0];
				default: ;
			endcase
		end
	end

	// Strobes appear the cycle after the write
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			start <= 1'b0;
			push  <= 1'b0;
		end else begin
			start <= wr_en && (offset == REG_START) && s_din[0];
			push  <= wr_en && (offset == REG_PUSH) && s_din[0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			intr_en     <= 1'b0;
			irq_pending <= 1'b0;
			s_interrupt <= 1'b0;
		end else begin
			if (wr_en && offset == REG_INTR_EN)
				intr_en <= s_din[0];
			if (done)
				irq_pending <= 1'b1; // Set wins over a clear in the same cycle
			else if (wr_en && offset == REG_INTR && s_din[0])
				irq_pending <= 1'b0;
			s_interrupt <= irq_pending & intr_en;
		end
	end

	always_comb begin
		case (offset)
			REG_INTR:    rd_data = word_t'(irq_pending);
			REG_INTR_EN: rd_data = word_t'(intr_en);
			REG_SRC:     rd_data = word_t'(src_r);
			REG_DEST:    rd_data = word_t'(dest_r);
			REG_SIZE:    rd_data = word_t'(size_r);
			REG_STATUS:  rd_data = word_t'(status); // Live engine status
			default:     rd_data = '0;
		endcase
	end

	// Read data held until the next read
	always_ff @(posedge clk) begin
		if (rd_en)
			s_dout <= rd_data;
	end

	assign desc.push = push;
	assign desc.src  = src_r;
	assign desc.dest = dest_r;
	assign desc.size = size_r;

endmodule

//--- hdl/dmac_top.sv
// DMA controller top level: register block, descriptor FIFO, copy engine
module dmac_top #(
	parameter int DESC_DEPTH = dmac_pkg::DESC_DEPTH_DEFAULT
) (
	input  logic            clk,
	input  logic            reset_n,
	input  logic            m_grant,
	input  dmac_pkg::word_t m_din,
	input  logic            s_sel,
	input  logic            s_wr,
	input  logic [15:0]     s_addr,
	input  dmac_pkg::word_t s_din,
	output logic            m_req,
	output logic            m_wr,
	output dmac_pkg::addr_t m_addr,
	output dmac_pkg::word_t m_dout,
	output dmac_pkg::word_t s_dout,
	output logic            s_interrupt
);
	import dmac_pkg::*;

	logic    start;
	logic    irq_pending;
	logic    overflow;
	logic    done;
	status_t status;

	desc_push_if push_bus ();
	desc_pop_if  pop_bus ();

	dmac_regs u_regs (
		.clk         (clk),
		.reset_n     (reset_n),
		.s_sel       (s_sel),
		.s_wr        (s_wr),
		.s_addr      (s_addr),
		.s_din       (s_din),
		.s_dout      (s_dout),
		.s_interrupt (s_interrupt),
		.start       (start),
		.irq_pending (irq_pending),
		.done        (done),
		.status      (status),
		.desc        (push_bus.regs)
	);

	dmac_desc_fifo #(.DESC_DEPTH(DESC_DEPTH)) u_fifo (
		.clk      (clk),
		.reset_n  (reset_n),
		.wr       (push_bus.fifo),
		.rd       (pop_bus.fifo),
		.overflow (overflow)
	);

	dmac_engine u_engine (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.irq_pending (irq_pending),
		.overflow    (overflow),
		.done        (done),
		.status      (status),
		.desc        (pop_bus.engine),
		.m_req       (m_req),
		.m_grant     (m_grant),
		.m_wr        (m_wr),
		.m_addr      (m_addr),
		.m_dout      (m_dout),
		.m_din       (m_din)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module dmac_tb -f dmac_top.f -o Vdmac_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vdmac_tb > sim.log 2>&1
sim_status=$?

if grep -q "Regression failed" sim.log || [ $sim_status -ne 0 ]; then
	echo "Simulation FAILED (status $sim_status), see sim.log"
	exit 1
fi
echo "Simulation OK"
exit 0
